// ==== thumb_ctrl_pkg.sv ====
package thumb_ctrl_pkg;

    // widths fixed by the 16-bit instruction set and the 32-bit datapath
    typedef logic [15:0] instr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  reg_list_t;
    typedef logic [3:0]  step_t;

    typedef enum logic [3:0] {
        ALU_ADD       = 4'd0,
        ALU_SUB       = 4'd1,
        ALU_AND       = 4'd2,
        ALU_OR        = 4'd3,
        ALU_XOR       = 4'd4,
        ALU_BIT_CLEAR = 4'd5,
        ALU_NOT       = 4'd6,
        ALU_MUL       = 4'd7,
        ALU_LSL       = 4'd8,
        ALU_LSR       = 4'd9,
        ALU_ASR       = 4'd10,
        ALU_ROR       = 4'd11,
        ALU_ADC       = 4'd12,
        ALU_SBC       = 4'd13
    } alu_op_e;

    // the accumulator-immediate source carries the running offset of a multiple transfer
    typedef enum logic [1:0] {
        SRC_REG     = 2'd0,
        SRC_IMM     = 2'd1,
        SRC_ZERO    = 2'd2,
        SRC_ACC_IMM = 2'd3
    } src_sel_e;

    typedef enum logic [2:0] {
        FMT_IMM_SHIFT  = 3'd0,
        FMT_DATA_PROC  = 3'd1,
        FMT_STORE_MULT = 3'd2,
        FMT_LOAD_MULT  = 3'd3,
        FMT_OTHER      = 3'd4
    } fmt_e;

    typedef struct packed {
        logic      update_flag;
        logic      mem_write;
        logic      mem_read;
        logic      reg_write;
        logic      data_from_mem;
        src_sel_e  alu_in1_sel;
        src_sel_e  alu_in2_sel;
        alu_op_e   alu_op;
        word_t     imm;
        reg_addr_t reg_addr;
        logic      addr2_from_ctrl;
        logic      dest_from_ctrl;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '{
        update_flag:     1'b0,
        mem_write:       1'b0,
        mem_read:        1'b0,
        reg_write:       1'b0,
        data_from_mem:   1'b0,
        alu_in1_sel:     SRC_REG,
        alu_in2_sel:     SRC_REG,
        alu_op:          ALU_ADD,
        imm:             '0,
        reg_addr:        '0,
        addr2_from_ctrl: 1'b0,
        dest_from_ctrl:  1'b0
    };

    localparam int unsigned BYTES_PER_REG = 4;

    // shift/add/sub/move/compare immediate class, instruction bits 13:9
    // the low bits left open belong to the shift amount or to the destination register
    localparam logic [4:0] OP_LSL_IMM  = 5'b000??;
    localparam logic [4:0] OP_LSR_IMM  = 5'b001??;
    localparam logic [4:0] OP_ASR_IMM  = 5'b010??;
    localparam logic [4:0] OP_ADD_REG  = 5'b01100;
    localparam logic [4:0] OP_SUB_REG  = 5'b01101;
    localparam logic [4:0] OP_ADD_IMM3 = 5'b01110;
    localparam logic [4:0] OP_SUB_IMM3 = 5'b01111;
    localparam logic [4:0] OP_MOV_IMM8 = 5'b100??;
    localparam logic [4:0] OP_CMP_IMM8 = 5'b101??;
    localparam logic [4:0] OP_ADD_IMM8 = 5'b110??;
    localparam logic [4:0] OP_SUB_IMM8 = 5'b111??;

    // data-processing register class, instruction bits 9:6
    localparam logic [3:0] DP_AND = 4'b0000;
    localparam logic [3:0] DP_EOR = 4'b0001;
    localparam logic [3:0] DP_LSL = 4'b0010;
    localparam logic [3:0] DP_LSR = 4'b0011;
    localparam logic [3:0] DP_ASR = 4'b0100;
    localparam logic [3:0] DP_ADC = 4'b0101;
    localparam logic [3:0] DP_SBC = 4'b0110;
    localparam logic [3:0] DP_ROR = 4'b0111;
    localparam logic [3:0] DP_TST = 4'b1000;
    localparam logic [3:0] DP_NEG = 4'b1001;
    localparam logic [3:0] DP_CMP = 4'b1010;
    localparam logic [3:0] DP_CMN = 4'b1011;
    localparam logic [3:0] DP_ORR = 4'b1100;
    localparam logic [3:0] DP_MUL = 4'b1101;
    localparam logic [3:0] DP_BIC = 4'b1110;
    localparam logic [3:0] DP_MVN = 4'b1111;

endpackage

// ==== alu_op_decoder.sv ====
module alu_op_decoder import thumb_ctrl_pkg::*; (
    input  instr_t     instr_i,
    output ctrl_word_t alu_word_o
);

    logic [4:0] shift_code;
    logic [3:0] dp_code;
    word_t      imm_shift;
    word_t      imm3;
    word_t      imm8;

    assign shift_code = instr_i[13:9];
    assign dp_code    = instr_i[9:6];

    // immediate fields, zero extended to the ALU width
    assign imm_shift = word_t'(instr_i[10:6]);
    assign imm3      = word_t'(instr_i[8:6]);
    assign imm8      = word_t'(instr_i[7:0]);

    always_comb begin
        alu_word_o = CTRL_IDLE;

        // every ALU form sets the flags, and nearly all of them write a register
        alu_word_o.update_flag = 1'b1;
        alu_word_o.reg_write   = 1'b1;

        // bit 14 tells the data-processing encoding apart from the shift/immediate one
        // whether either one applies at all is decided in the merge stage
        if (instr_i[14]) begin
            case (dp_code)
                DP_AND: alu_word_o.alu_op = ALU_AND;
                DP_EOR: alu_word_o.alu_op = ALU_XOR;
                DP_LSL: alu_word_o.alu_op = ALU_LSL;
                DP_LSR: alu_word_o.alu_op = ALU_LSR;
                DP_ASR: alu_word_o.alu_op = ALU_ASR;
                DP_ADC: alu_word_o.alu_op = ALU_ADC;
                DP_SBC: alu_word_o.alu_op = ALU_SBC;
                DP_ROR: alu_word_o.alu_op = ALU_ROR;
                DP_TST: begin
                    alu_word_o.alu_op    = ALU_AND;
                    alu_word_o.reg_write = 1'b0;
                end
                DP_NEG: begin
                    // negate is computed as zero minus the operand
                    alu_word_o.alu_op      = ALU_SUB;
                    alu_word_o.alu_in1_sel = SRC_ZERO;
                end
                DP_CMP: begin
                    alu_word_o.alu_op    = ALU_SUB;
                    alu_word_o.reg_write = 1'b0;
                end
                DP_CMN: begin
                    alu_word_o.alu_op    = ALU_ADD;
                    alu_word_o.reg_write = 1'b0;
                end
                DP_ORR: alu_word_o.alu_op = ALU_OR;
                DP_MUL: alu_word_o.alu_op = ALU_MUL;
                DP_BIC: alu_word_o.alu_op = ALU_BIT_CLEAR;
                DP_MVN: alu_word_o.alu_op = ALU_NOT;
                default: alu_word_o.alu_op = ALU_ADD;
            endcase
        end else begin
            casez (shift_code)
                OP_LSL_IMM: begin
                    alu_word_o.alu_op      = ALU_LSL;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm_shift;
                end
                OP_LSR_IMM: begin
                    alu_word_o.alu_op      = ALU_LSR;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm_shift;
                end
                OP_ASR_IMM: begin
                    alu_word_o.alu_op      = ALU_ASR;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm_shift;
                end
                OP_ADD_REG: alu_word_o.alu_op = ALU_ADD;
                OP_SUB_REG: alu_word_o.alu_op = ALU_SUB;
                OP_ADD_IMM3: begin
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm3;
                end
                OP_SUB_IMM3: begin
                    alu_word_o.alu_op      = ALU_SUB;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm3;
                end
                OP_MOV_IMM8: begin
                    // move is zero plus the immediate
                    alu_word_o.alu_in1_sel = SRC_ZERO;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm8;
                end
                OP_CMP_IMM8: begin
                    alu_word_o.alu_op      = ALU_SUB;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm8;
                    alu_word_o.reg_write   = 1'b0;
                end
                OP_ADD_IMM8: begin
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm8;
                end
                OP_SUB_IMM8: begin
                    alu_word_o.alu_op      = ALU_SUB;
                    alu_word_o.alu_in2_sel = SRC_IMM;
                    alu_word_o.imm         = imm8;
                end
                default: alu_word_o.alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

// ==== reg_list_sequencer.sv ====
module reg_list_sequencer import thumb_ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       valid_i,
    input  instr_t     instr_i,
    input  logic       seq_en_i,
    input  logic       is_load_i,
    output ctrl_word_t seq_word_o,
    output logic       seq_stall_o
);

    // registers of the list not yet transferred, all ones while idle
    reg_list_t mask_q;
    step_t     step_q;
    logic      base_in_list_q;

    reg_list_t reg_list;
    reg_list_t pending;
    reg_addr_t base_addr;
    reg_addr_t pick_addr;
    step_t     list_count;
    step_t     load_slot;

    function automatic reg_addr_t lowest_set(input reg_list_t list);
        reg_addr_t idx;
        idx = '0;
        for (int i = 7; i >= 0; i--) begin
            if (list[i]) begin
                idx = reg_addr_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic reg_addr_t highest_set(input reg_list_t list);
        reg_addr_t idx;
        idx = '0;
        for (int i = 0; i < 8; i++) begin
            if (list[i]) begin
                idx = reg_addr_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic step_t count_regs(input reg_list_t list);
        step_t sum;
        sum = '0;
        for (int i = 0; i < 8; i++) begin
            sum = sum + step_t'(list[i]);
        end
        return sum;
    endfunction

    assign reg_list   = instr_i[7:0];
    assign base_addr  = {1'b0, instr_i[10:8]};
    assign pending    = reg_list & mask_q;
    assign list_count = count_regs(reg_list);

    // stores walk the list upwards, loads walk it downwards
    assign pick_addr = is_load_i ? highest_set(pending) : lowest_set(pending);

    // loads fill the block from the top, so the first load uses the last slot
    assign load_slot = list_count - step_q - step_t'(1);

    assign seq_stall_o = valid_i && seq_en_i && (pending != '0);

    always_comb begin
        seq_word_o             = CTRL_IDLE;
        seq_word_o.alu_in2_sel = SRC_ACC_IMM;
        if (seq_stall_o) begin
            seq_word_o.reg_addr = pick_addr;
            if (is_load_i) begin
                seq_word_o.reg_write      = 1'b1;
                seq_word_o.data_from_mem  = 1'b1;
                seq_word_o.dest_from_ctrl = 1'b1;
                seq_word_o.imm            = word_t'(BYTES_PER_REG * load_slot);
            end else begin
                seq_word_o.mem_write       = 1'b1;
                seq_word_o.addr2_from_ctrl = 1'b1;
                seq_word_o.imm             = word_t'(BYTES_PER_REG * step_q);
            end
        end else begin
            // final cycle moves the base past the whole block
            seq_word_o.reg_addr       = base_addr;
            seq_word_o.dest_from_ctrl = 1'b1;
            seq_word_o.alu_op         = ALU_ADD;
            seq_word_o.imm            = word_t'(BYTES_PER_REG * list_count);
            // a loaded base keeps the value it got from memory
            seq_word_o.reg_write      = !(is_load_i && base_in_list_q);
        end
    end

    // the walk restarts whenever the instruction is consumed, dropped or not a multiple
    always_ff @(posedge clk_i) begin
        if (reset_i || !seq_stall_o) begin
            mask_q         <= '1;
            step_q         <= '0;
            base_in_list_q <= 1'b0;
        end else begin
            mask_q <= mask_q & ~(reg_list_t'(1) << pick_addr[2:0]);
            step_q <= step_q + step_t'(1);
            if (pick_addr == base_addr) begin
                base_in_list_q <= 1'b1;
            end
        end
    end

endmodule

// ==== ctrl_merge.sv ====
module ctrl_merge import thumb_ctrl_pkg::*; (
    input  logic       valid_i,
    input  instr_t     instr_i,
    input  ctrl_word_t alu_word_i,
    input  ctrl_word_t seq_word_i,
    input  logic       seq_stall_i,
    output logic       seq_en_o,
    output logic       is_load_o,
    output ctrl_word_t ctrl_o,
    output logic       stall_o
);

    fmt_e fmt;
    logic is_multiple;

    // format classes by their fixed leading bits
    always_comb begin
        if (instr_i[15:14] == 2'b00) begin
            fmt = FMT_IMM_SHIFT;
        end else if (instr_i[15:10] == 6'b010000) begin
            fmt = FMT_DATA_PROC;
        end else if (instr_i[15:12] == 4'b1100) begin
            fmt = instr_i[11] ? FMT_LOAD_MULT : FMT_STORE_MULT;
        end else begin
            fmt = FMT_OTHER;
        end
    end

    assign is_multiple = (fmt == FMT_STORE_MULT) || (fmt == FMT_LOAD_MULT);
    assign seq_en_o    = valid_i && is_multiple;
    assign is_load_o   = (fmt == FMT_LOAD_MULT);

    // only a multiple may hold the pipeline
    assign stall_o = seq_en_o && seq_stall_i;

    always_comb begin
        if (!valid_i) begin
            ctrl_o = CTRL_IDLE;
        end else begin
            case (fmt)
                FMT_IMM_SHIFT,
                FMT_DATA_PROC:  ctrl_o = alu_word_i;
                FMT_STORE_MULT,
                FMT_LOAD_MULT:  ctrl_o = seq_word_i;
                default:        ctrl_o = CTRL_IDLE;
            endcase
        end
    end

endmodule

// ==== thumb_ctrl_top.sv ====
module thumb_ctrl_top import thumb_ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       valid_i,
    input  instr_t     instr_i,
    output ctrl_word_t ctrl_o,
    output logic       stall_o
);

    ctrl_word_t alu_word;
    ctrl_word_t seq_word;
    logic       seq_stall;
    logic       seq_en;
    logic       is_load;

    alu_op_decoder u_alu_op_decoder (
        .instr_i    (instr_i),
        .alu_word_o (alu_word)
    );

    // multi-register walker, enabled by the merge stage
    reg_list_sequencer u_reg_list_sequencer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .seq_en_i    (seq_en),
        .is_load_i   (is_load),
        .seq_word_o  (seq_word),
        .seq_stall_o (seq_stall)
    );

    ctrl_merge u_ctrl_merge (
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .alu_word_i  (alu_word),
        .seq_word_i  (seq_word),
        .seq_stall_i (seq_stall),
        .seq_en_o    (seq_en),
        .is_load_o   (is_load),
        .ctrl_o      (ctrl_o),
        .stall_o     (stall_o)
    );

endmodule

// ==== tb_thumb_ctrl_model.svh ====
`ifndef TB_THUMB_CTRL_MODEL_SVH
`define TB_THUMB_CTRL_MODEL_SVH

// number of registers named in an STM/LDM list
function automatic int count_listed(input reg_list_t list);
    int n;
    n = 0;
    for (int r = 0; r < 8; r++) begin
        n += int'(list[r]);
    end
    return n;
endfunction

// register at position pos, counted upwards from R0 or downwards from R7
function automatic reg_addr_t listed_reg(input reg_list_t list, input int pos,
                                         input logic from_top);
    int        seen;
    int        r;
    reg_addr_t found;
    seen  = 0;
    found = '0;
    for (int k = 0; k < 8; k++) begin
        r = from_top ? 7 - k : k;
        if (list[r]) begin
            if (seen == pos) begin
                found = reg_addr_t'(r);
            end
            seen++;
        end
    end
    return found;
endfunction

function automatic ctrl_word_t expect_dp(input logic [3:0] code);
    ctrl_word_t w;
    w             = CTRL_IDLE;
    w.update_flag = 1'b1;
    // the three compare forms only set flags
    w.reg_write   = !(code inside {DP_TST, DP_CMP, DP_CMN});
    case (code)
        DP_AND, DP_TST: w.alu_op = ALU_AND;
        DP_EOR: w.alu_op = ALU_XOR;
        DP_LSL: w.alu_op = ALU_LSL;
        DP_LSR: w.alu_op = ALU_LSR;
        DP_ASR: w.alu_op = ALU_ASR;
        DP_ADC: w.alu_op = ALU_ADC;
        DP_SBC: w.alu_op = ALU_SBC;
        DP_ROR: w.alu_op = ALU_ROR;
        DP_NEG: begin
            w.alu_op      = ALU_SUB;
            w.alu_in1_sel = SRC_ZERO;
        end
        DP_CMP: w.alu_op = ALU_SUB;
        DP_CMN: w.alu_op = ALU_ADD;
        DP_ORR: w.alu_op = ALU_OR;
        DP_MUL: w.alu_op = ALU_MUL;
        DP_BIC: w.alu_op = ALU_BIT_CLEAR;
        default: w.alu_op = ALU_NOT;
    endcase
    return w;
endfunction

// shift/add/sub/move/compare class, split by bits 13:11 first
function automatic ctrl_word_t expect_shift(input instr_t instr);
    ctrl_word_t w;
    w             = CTRL_IDLE;
    w.update_flag = 1'b1;
    w.reg_write   = 1'b1;
    w.alu_in2_sel = SRC_IMM;
    w.imm         = word_t'(instr[7:0]);
    case (instr[13:11])
        3'b000: w.alu_op = ALU_LSL;
        3'b001: w.alu_op = ALU_LSR;
        3'b010: w.alu_op = ALU_ASR;
        3'b011: begin
            if (instr[9]) begin
                w.alu_op = ALU_SUB;
            end
            w.imm = word_t'(instr[8:6]);
            // bit 10 clear means the second operand is a register
            if (!instr[10]) begin
                w.alu_in2_sel = SRC_REG;
                w.imm         = '0;
            end
        end
        3'b100: w.alu_in1_sel = SRC_ZERO;
        3'b101: begin
            w.alu_op    = ALU_SUB;
            w.reg_write = 1'b0;
        end
        3'b110: w.alu_op = ALU_ADD;
        default: w.alu_op = ALU_SUB;
    endcase
    if (instr[13:11] < 3'b011) begin
        w.imm = word_t'(instr[10:6]);
    end
    return w;
endfunction

function automatic ctrl_word_t expect_transfer(input logic is_load, input reg_list_t list,
                                               input int step);
    ctrl_word_t w;
    int         n;
    n             = count_listed(list);
    w             = CTRL_IDLE;
    w.alu_in2_sel = SRC_ACC_IMM;
    w.reg_addr    = listed_reg(list, step, is_load);
    if (is_load) begin
        w.reg_write      = 1'b1;
        w.data_from_mem  = 1'b1;
        w.dest_from_ctrl = 1'b1;
        w.imm            = word_t'(BYTES_PER_REG * (n - 1 - step));
    end else begin
        w.mem_write       = 1'b1;
        w.addr2_from_ctrl = 1'b1;
        w.imm             = word_t'(BYTES_PER_REG * step);
    end
    return w;
endfunction

function automatic ctrl_word_t expect_writeback(input logic is_load, input logic [2:0] base,
                                                input reg_list_t list);
    ctrl_word_t w;
    w                = CTRL_IDLE;
    w.alu_in2_sel    = SRC_ACC_IMM;
    w.alu_op         = ALU_ADD;
    w.reg_addr       = {1'b0, base};
    w.dest_from_ctrl = 1'b1;
    w.imm            = word_t'(BYTES_PER_REG * count_listed(list));
    // a base that was loaded from memory keeps the loaded value
    w.reg_write      = !(is_load && list[base]);
    return w;
endfunction

`endif

// ==== tb_thumb_ctrl.sv ====
module tb_thumb_ctrl import thumb_ctrl_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SETTLE       = 2;
    localparam int SEQ_WORST    = 9;
    localparam int N_RANDOM_SEQ = 12;
    localparam int N_ABORT      = 4;
    // each test is counted at the worst sequence length, an abort as two sequences
    localparam int TEST_SLOTS    = 2 + 16 + 32 + 2 * N_RANDOM_SEQ + 5 + 2 * N_ABORT;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_SLOTS * SEQ_WORST + 50) * CLK_PERIOD;
    localparam int unsigned SEED = 32'h0066271b;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       valid_i;
    instr_t     instr_i;
    ctrl_word_t ctrl_o;
    logic       stall_o;

    // expectation for the cycle that ends at the next rising edge
    ctrl_word_t exp_word;
    logic       exp_stall;
    logic       check_en;
    string      test_name;

    `include "tb_thumb_ctrl_model.svh"

    thumb_ctrl_top dut0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .instr_i (instr_i),
        .ctrl_o  (ctrl_o),
        .stall_o (stall_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic halt_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_word_error(input ctrl_word_t expected, input ctrl_word_t actual);
        halt_with_failure($sformatf("error: %s: control word expected %h actual %h",
                                    test_name, expected, actual));
    endtask

    task automatic report_value_error(input string what, input int expected, input int actual);
        halt_with_failure($sformatf("error: %s: %s expected %0d actual %0d",
                                    test_name, what, expected, actual));
    endtask

    assert property (@(posedge clk_i) disable iff (reset_i || !check_en) ctrl_o == exp_word)
    else report_word_error(exp_word, $sampled(ctrl_o));

    assert property (@(posedge clk_i) disable iff (reset_i || !check_en) stall_o == exp_stall)
    else report_value_error("stall", int'(exp_stall), int'($sampled(stall_o)));

    assert property (@(posedge clk_i) disable iff (reset_i) !valid_i |-> !stall_o)
    else halt_with_failure("stall is high while no valid instruction is presented");

    initial begin
        #(WATCHDOG_TIME);
        halt_with_failure("timeout: the tests did not finish within the time limit");
    end

    // drives one cycle and reads the stall once the combinational outputs have settled
    task automatic drive_cycle(input instr_t instr, input logic valid, input ctrl_word_t expected,
                               input logic expect_stall, output logic seen_stall);
        @(negedge clk_i);
        instr_i   = instr;
        valid_i   = valid;
        exp_word  = expected;
        exp_stall = expect_stall;
        check_en  = 1'b1;
        #(SETTLE);
        seen_stall = stall_o;
    endtask

    // holds an STM/LDM valid until the unit releases the stall
    task automatic run_multiple(input logic is_load, input logic [2:0] base,
                                input reg_list_t list);
        instr_t     instr;
        ctrl_word_t expected;
        int         n;
        int         step;
        int         stall_cnt;
        logic       stalled;
        instr     = {4'b1100, is_load, base, list};
        n         = count_listed(list);
        step      = 0;
        stall_cnt = 0;
        stalled   = 1'b1;
        while (stalled) begin
            if (step < n) begin
                expected = expect_transfer(is_load, list, step);
            end else begin
                expected = expect_writeback(is_load, base, list);
            end
            drive_cycle(instr, 1'b1, expected, step < n, stalled);
            if (stalled) begin
                stall_cnt++;
            end
            step++;
        end
        assert (stall_cnt == n)
        else report_value_error("stall cycles", n, stall_cnt);
    endtask

    task automatic run_abort(input logic is_load, input logic [2:0] base, input reg_list_t list,
                             input int cut);
        instr_t instr;
        logic   stalled;
        instr = {4'b1100, is_load, base, list};
        for (int step = 0; step < cut; step++) begin
            drive_cycle(instr, 1'b1, expect_transfer(is_load, list, step), 1'b1, stalled);
        end
        // one cycle without a valid instruction returns the walk to idle
        drive_cycle(instr, 1'b0, CTRL_IDLE, 1'b0, stalled);
        run_multiple(is_load, base, list);
    endtask

    initial begin
        instr_t     instr;
        reg_list_t  list;
        logic [2:0] base;
        logic       stalled;
        int         cut;

        void'($urandom(SEED));
        reset_i   = 1'b1;
        valid_i   = 1'b0;
        instr_i   = '0;
        check_en  = 1'b0;
        exp_word  = CTRL_IDLE;
        exp_stall = 1'b0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        test_name = "idle after reset";
        drive_cycle(16'($urandom), 1'b0, CTRL_IDLE, 1'b0, stalled);

        for (int code = 0; code < 16; code++) begin
            test_name = $sformatf("data-processing code %0d", code);
            instr     = {6'b010000, code[3:0], 6'($urandom)};
            drive_cycle(instr, 1'b1, expect_dp(code[3:0]), 1'b0, stalled);
        end

        for (int op = 0; op < 32; op++) begin
            test_name = $sformatf("shift/immediate code %0d", op);
            instr     = {2'b00, op[4:0], 9'($urandom)};
            drive_cycle(instr, 1'b1, expect_shift(instr), 1'b0, stalled);
        end

        for (int t = 0; t < N_RANDOM_SEQ; t++) begin
            test_name = "stm random list";
            run_multiple(1'b0, 3'($urandom), 8'($urandom));
            test_name = "ldm random list";
            run_multiple(1'b1, 3'($urandom), 8'($urandom));
        end

        base      = 3'($urandom);
        list      = 8'($urandom);
        test_name = "ldm base in list";
        run_multiple(1'b1, base, list | (8'd1 << base));
        test_name = "ldm base not in list";
        run_multiple(1'b1, base, list & ~(8'd1 << base));
        test_name = "stm empty list";
        run_multiple(1'b0, base, 8'h00);
        test_name = "ldm empty list";
        run_multiple(1'b1, base, 8'h00);
        test_name = "stm full list";
        run_multiple(1'b0, base, 8'hff);

        for (int t = 0; t < N_ABORT; t++) begin
            // R0 and R7 are always listed so the walk can be cut in the middle
            list      = 8'($urandom) | 8'h81;
            base      = 3'($urandom);
            cut       = 1 + int'($urandom % 32'(count_listed(list) - 1));
            test_name = $sformatf("abort after %0d transfers", cut);
            run_abort(t[0], base, list, cut);
        end

        test_name = "final idle";
        drive_cycle('0, 1'b0, CTRL_IDLE, 1'b0, stalled);
        @(negedge clk_i);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== thumb_ctrl_top.f ====
+incdir+.
thumb_ctrl_pkg.sv
alu_op_decoder.sv
reg_list_sequencer.sv
ctrl_merge.sv
thumb_ctrl_top.sv
tb_thumb_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f thumb_ctrl_top.f \
    --top-module tb_thumb_ctrl \
    -o sim_thumb_ctrl

./obj_dir/sim_thumb_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
